// File: include/vfp_defs.svh
// Vector/FP commit glue sizing macros shared by the RTL and the testbench
`ifndef VFP_DEFS_SVH
`define VFP_DEFS_SVH

// One vector register
`define VFP_VLEN 64

// Register group
`define VFP_GROUP_REGS 8
`define VFP_GROUP_CNT_W 3
`define VFP_COMMIT_WIDTH (`VFP_VLEN * `VFP_GROUP_REGS)

// Load queue
`define VFP_LQ_DEPTH 8
`define VFP_LQ_ID_W 3

// Memory request fields, low VFP_LQ_ID_W bits of the id index the queue
`define VFP_REQ_ID_W 8
`define VFP_ADDR_W 32

// Vector length CSR
`define VFP_VL_W 7

// Exception flags, same layout as fflags
`define VFP_EXC_W 5

`endif

// File: hdl/vfp_pkg.sv
// Shared enum types for commit source selection and memory request size
package vfp_pkg;

   // Source that produced the current commit
   typedef enum logic [2:0] {
      COMMIT_NONE   = 3'd0,
      COMMIT_SCALAR = 3'd1,
      COMMIT_FP     = 3'd2,
      COMMIT_VECTOR = 3'd3,
      COMMIT_STORE  = 3'd4
   } commit_src_e;

   // Request size, log2 of the byte count
   typedef enum logic [2:0] {
      MEM_SIZE_BYTE  = 3'd0,
      MEM_SIZE_HALF  = 3'd1,
      MEM_SIZE_WORD  = 3'd2,
      MEM_SIZE_DWORD = 3'd3,
      MEM_SIZE_QUAD  = 3'd4
   } mem_size_e;

endpackage

// File: hdl/lq_last_if.sv
// Last-beat information shared by the queue tracker, request filter and commit logic
`include "vfp_defs.svh"

interface lq_last_if;

   // Last bit of the entry at the commit read pointer
   logic                    head_last;
   // Queue index of the request being presented, and its last bit
   logic [`VFP_LQ_ID_W-1:0] req_lqid;
   logic                    req_last;
   // A last store was accepted this cycle
   logic                    store_done;

   modport tracker (
      input  req_lqid,
      output head_last,
      output req_last
   );

   modport filter (
      input  req_last,
      output req_lqid,
      output store_done
   );

   modport commit (
      input  head_last,
      input  store_done
   );

endinterface

// File: hdl/lq_last_tracker.sv
// Load-queue last-beat tracker with per-entry last bits and a commit read pointer
`include "vfp_defs.svh"

module lq_last_tracker (
   input  logic                    i_clk,
   input  logic                    i_reset,
   input  logic                    i_id_mem_lqalloc,
   input  logic                    i_id_mem_lq_done,
   input  logic                    i_mem_lq_commit,
   input  logic [`VFP_LQ_ID_W-1:0] i_mem_id_lqnxtid,
   lq_last_if.tracker              lq
);

   logic [`VFP_LQ_DEPTH-1:0] lq_last;
   logic [`VFP_LQ_ID_W-1:0]  alloc_id;
   logic [`VFP_LQ_ID_W-1:0]  rd_ptr;

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         rd_ptr <= '0;
      end else if (i_mem_lq_commit) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Done with alloc marks the new entry, done alone finishes the latest one
   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lq_last  <= '0;
         alloc_id <= '0;
      end else begin
         if (i_id_mem_lqalloc) begin
            lq_last[i_mem_id_lqnxtid] <= i_id_mem_lq_done;
            alloc_id                  <= i_mem_id_lqnxtid;
         end else if (i_id_mem_lq_done) begin
            lq_last[alloc_id] <= 1'b1;
         end
      end
   end

   assign lq.head_last = lq_last[rd_ptr];
   assign lq.req_last  = lq_last[lq.req_lqid];

endmodule

// File: hdl/mem_req_filter.sv
// Memory request filter dropping empty loads, answering them locally, gating the last flag
`include "vfp_defs.svh"

module mem_req_filter (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  logic                     i_mu_req,
   input  logic                     i_mu_load,
   input  logic                     i_mu_store,
   input  logic                     i_mu_last,
   input  logic [`VFP_VLEN/8-1:0]   i_mu_byten,
   input  logic [`VFP_REQ_ID_W-1:0] i_mu_req_id,
   input  logic                     i_data_req_rtr,
   output logic                     o_data_req,
   output logic                     o_mem_last,
   output logic                     o_local_rsp_vld,
   output logic [`VFP_REQ_ID_W-1:0] o_local_rsp_id,
   lq_last_if.filter                lq
);

   logic empty_load;
   logic empty_load_acc;

   // A load with no byte enabled never reaches the memory system
   assign empty_load     = i_mu_load && ~|i_mu_byten;
   assign o_data_req     = i_mu_req && !empty_load;

   // The empty load still needs ready, so the answer keeps request order
   assign empty_load_acc = i_mu_req && i_data_req_rtr && empty_load;

   assign lq.req_lqid = i_mu_req_id[`VFP_LQ_ID_W-1:0];
   assign o_mem_last  = i_mu_last && lq.req_last;

   assign lq.store_done = o_data_req && i_data_req_rtr && i_mu_store && o_mem_last;

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         o_local_rsp_vld <= 1'b0;
      end else begin
         o_local_rsp_vld <= empty_load_acc;
      end
   end

   always_ff @(posedge i_clk) begin
      if (empty_load_acc) begin
         o_local_rsp_id <= i_mu_req_id;
      end
   end

endmodule

// File: hdl/vec_commit_assembler.sv
// Vector register group accumulation and commit source selection
`include "vfp_defs.svh"

module vec_commit_assembler (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  logic [`VFP_VL_W-1:0]         i_csr_vl,
   input  logic                         i_mem_rf_wr,
   input  logic                         i_mem_fp_rf_wr,
   input  logic                         i_mem_vrf_wr,
   input  logic                         i_vec_nonstore_commit,
   input  logic [63:0]                  i_mem_rf_wrdata,
   input  logic [63:0]                  i_mem_fp_rf_wrdata,
   input  logic [`VFP_VLEN-1:0]         i_mem_vrf_wrdata,
   input  logic [`VFP_EXC_W-1:0]        i_mem_vrf_wrexc,
   output logic                         o_instrn_commit_valid,
   output logic [`VFP_COMMIT_WIDTH-1:0] o_instrn_commit_data,
   output logic [`VFP_GROUP_REGS-1:0]   o_instrn_commit_mask,
   output logic [`VFP_EXC_W-1:0]        o_instrn_commit_fflags,
   lq_last_if.commit                    lq
);

   vfp_pkg::commit_src_e commit_src;

   logic [`VFP_GROUP_CNT_W-1:0]  grp_cnt;
   logic [`VFP_COMMIT_WIDTH-1:0] data_q;
   logic [`VFP_COMMIT_WIDTH-1:0] data_nxt;
   logic [`VFP_GROUP_REGS-1:0]   mask_q;
   logic [`VFP_GROUP_REGS-1:0]   mask_nxt;
   logic [`VFP_EXC_W-1:0]        exc_q;
   logic [`VFP_EXC_W-1:0]        exc_nxt;

   // Group so far plus the write in flight
   always_comb begin
      data_nxt = data_q;
      mask_nxt = mask_q;
      exc_nxt  = exc_q;
      if (i_mem_vrf_wr) begin
         data_nxt[`VFP_VLEN*grp_cnt +: `VFP_VLEN] = i_mem_vrf_wrdata;
         mask_nxt[grp_cnt]                        = |i_csr_vl;
         exc_nxt                                  = exc_q | i_mem_vrf_wrexc;
      end
   end

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         grp_cnt <= '0;
         data_q  <= '0;
         mask_q  <= '0;
         exc_q   <= '0;
      end else if (o_instrn_commit_valid) begin
         grp_cnt <= '0;
         data_q  <= '0;
         mask_q  <= '0;
         exc_q   <= '0;
      end else if (i_mem_vrf_wr) begin
         grp_cnt <= grp_cnt + 1'b1;
         data_q  <= data_nxt;
         mask_q  <= mask_nxt;
         exc_q   <= exc_nxt;
      end
   end

   // Vector group only commits once its head entry has seen its last beat
   always_comb begin
      commit_src = vfp_pkg::COMMIT_NONE;
      if (i_mem_rf_wr) begin
         commit_src = vfp_pkg::COMMIT_SCALAR;
      end else if (i_mem_fp_rf_wr) begin
         commit_src = vfp_pkg::COMMIT_FP;
      end else if (i_vec_nonstore_commit && lq.head_last) begin
         commit_src = vfp_pkg::COMMIT_VECTOR;
      end else if (lq.store_done) begin
         commit_src = vfp_pkg::COMMIT_STORE;
      end
   end

   assign o_instrn_commit_valid = (commit_src != vfp_pkg::COMMIT_NONE);

   always_comb begin
      o_instrn_commit_data   = '0;
      o_instrn_commit_mask   = '0;
      o_instrn_commit_fflags = '0;
      case (commit_src)
         vfp_pkg::COMMIT_SCALAR: o_instrn_commit_data[63:0] = i_mem_rf_wrdata;
         vfp_pkg::COMMIT_FP:     o_instrn_commit_data[63:0] = i_mem_fp_rf_wrdata;
         vfp_pkg::COMMIT_VECTOR: begin
            o_instrn_commit_data   = data_nxt;
            o_instrn_commit_mask   = mask_nxt;
            o_instrn_commit_fflags = exc_nxt;
         end
         default: ;
      endcase
   end

endmodule

// File: hdl/vfp_commit_top.sv
// Commit and memory glue top level around the vector/FP execution pipeline
`include "vfp_defs.svh"

module vfp_commit_top (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  logic [`VFP_VL_W-1:0]         i_csr_vl,

   // Load queue bookkeeping
   input  logic                         i_id_mem_lqalloc,
   input  logic                         i_id_mem_lq_done,
   input  logic [`VFP_LQ_ID_W-1:0]      i_mem_id_lqnxtid,
   input  logic                         i_mem_lq_commit,

   // Requests from the memory unit
   input  logic                         i_mu_req,
   input  logic                         i_mu_load,
   input  logic                         i_mu_store,
   input  logic                         i_mu_last,
   input  logic [`VFP_VLEN/8-1:0]       i_mu_byten,
   input  logic [`VFP_REQ_ID_W-1:0]     i_mu_req_id,
   input  logic [`VFP_ADDR_W-1:0]       i_mu_addr,
   input  logic [`VFP_VLEN-1:0]         i_mu_wrdata,
   input  vfp_pkg::mem_size_e           i_mu_size,

   // Memory system
   output logic                         o_data_req,
   output logic [`VFP_ADDR_W-1:0]       o_data_addr,
   output logic [`VFP_VLEN/8-1:0]       o_data_byten,
   output logic [`VFP_VLEN-1:0]         o_wr_data,
   output logic [`VFP_REQ_ID_W-1:0]     o_data_req_id,
   output logic                         o_mem_load,
   output vfp_pkg::mem_size_e           o_mem_size,
   output logic                         o_mem_last,
   input  logic                         i_data_req_rtr,
   output logic                         o_local_rsp_vld,
   output logic [`VFP_REQ_ID_W-1:0]     o_local_rsp_id,

   // Register file writebacks
   input  logic                         i_mem_rf_wr,
   input  logic [63:0]                  i_mem_rf_wrdata,
   input  logic                         i_mem_fp_rf_wr,
   input  logic [63:0]                  i_mem_fp_rf_wrdata,
   input  logic                         i_mem_vrf_wr,
   input  logic [`VFP_VLEN-1:0]         i_mem_vrf_wrdata,
   input  logic [`VFP_EXC_W-1:0]        i_mem_vrf_wrexc,
   input  logic                         i_vec_nonstore_commit,

   // Commit
   output logic                         o_instrn_commit_valid,
   output logic [`VFP_COMMIT_WIDTH-1:0] o_instrn_commit_data,
   output logic [`VFP_GROUP_REGS-1:0]   o_instrn_commit_mask,
   output logic [`VFP_EXC_W-1:0]        o_instrn_commit_fflags
);

   lq_last_if u_lq_if ();

   // Request fields go out unchanged
   assign o_data_addr   = i_mu_addr;
   assign o_wr_data     = i_mu_wrdata;
   assign o_mem_size    = i_mu_size;
   assign o_data_req_id = i_mu_req_id;
   assign o_data_byten  = i_mu_byten;
   assign o_mem_load    = i_mu_load;

   lq_last_tracker u_tracker (
      .i_clk            (i_clk),
      .i_reset          (i_reset),
      .i_id_mem_lqalloc (i_id_mem_lqalloc),
      .i_id_mem_lq_done (i_id_mem_lq_done),
      .i_mem_lq_commit  (i_mem_lq_commit),
      .i_mem_id_lqnxtid (i_mem_id_lqnxtid),
      .lq               (u_lq_if.tracker)
   );

   mem_req_filter u_filter (
      .i_clk           (i_clk),
      .i_reset         (i_reset),
      .i_mu_req        (i_mu_req),
      .i_mu_load       (i_mu_load),
      .i_mu_store      (i_mu_store),
      .i_mu_last       (i_mu_last),
      .i_mu_byten      (i_mu_byten),
      .i_mu_req_id     (i_mu_req_id),
      .i_data_req_rtr  (i_data_req_rtr),
      .o_data_req      (o_data_req),
      .o_mem_last      (o_mem_last),
      .o_local_rsp_vld (o_local_rsp_vld),
      .o_local_rsp_id  (o_local_rsp_id),
      .lq              (u_lq_if.filter)
   );

   vec_commit_assembler u_assembler (
      .i_clk                  (i_clk),
      .i_reset                (i_reset),
      .i_csr_vl               (i_csr_vl),
      .i_mem_rf_wr            (i_mem_rf_wr),
      .i_mem_fp_rf_wr         (i_mem_fp_rf_wr),
      .i_mem_vrf_wr           (i_mem_vrf_wr),
      .i_vec_nonstore_commit  (i_vec_nonstore_commit),
      .i_mem_rf_wrdata        (i_mem_rf_wrdata),
      .i_mem_fp_rf_wrdata     (i_mem_fp_rf_wrdata),
      .i_mem_vrf_wrdata       (i_mem_vrf_wrdata),
      .i_mem_vrf_wrexc        (i_mem_vrf_wrexc),
      .o_instrn_commit_valid  (o_instrn_commit_valid),
      .o_instrn_commit_data   (o_instrn_commit_data),
      .o_instrn_commit_mask   (o_instrn_commit_mask),
      .o_instrn_commit_fflags (o_instrn_commit_fflags),
      .lq                     (u_lq_if.commit)
   );

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock source, free running square wave
module tb_clock_gen #(
   parameter int PERIOD = 100
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// File: verification/vfp_commit_props.sv
// Concurrent checks on empty-load handling and commit source selection
`include "vfp_defs.svh"

module vfp_commit_props (
   input logic                     i_clk,
   input logic                     i_reset,
   input logic                     i_mu_req,
   input logic                     i_mu_load,
   input logic                     i_mu_store,
   input logic [`VFP_VLEN/8-1:0]   i_mu_byten,
   input logic [`VFP_REQ_ID_W-1:0] i_mu_req_id,
   input logic                     i_data_req_rtr,
   input logic                     i_data_req,
   input logic                     i_mem_last,
   input logic                     i_local_rsp_vld,
   input logic [`VFP_REQ_ID_W-1:0] i_local_rsp_id,
   input logic                     i_rf_wr,
   input logic                     i_fp_rf_wr,
   input logic                     i_vec_commit,
   input logic                     i_head_last,
   input logic                     i_commit_valid,
   input vfp_pkg::commit_src_e     i_commit_src
);

   logic empty_load;
   logic store_acc;
   logic vec_ready;
   int   fail_cnt = 0;

   assign empty_load = i_mu_load && ~|i_mu_byten;
   assign store_acc  = i_data_req && i_data_req_rtr && i_mu_store && i_mem_last;
   assign vec_ready  = i_vec_commit && i_head_last;

   a_local_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_mu_req && i_data_req_rtr && empty_load)
      |=> (i_local_rsp_vld && (i_local_rsp_id == $past(i_mu_req_id))))
      else begin
         $error("No local response with the right id after an empty load");
         fail_cnt++;
      end

   a_no_empty_req: assert property (@(posedge i_clk) disable iff (i_reset)
      empty_load |-> !i_data_req)
      else begin
         $error("Empty load reached the memory request port");
         fail_cnt++;
      end

   // Every commit names a raised source, and no raised source is dropped
   a_commit_src: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_commit_valid == (i_rf_wr || i_fp_rf_wr || vec_ready || store_acc))
      && (i_commit_src != vfp_pkg::COMMIT_SCALAR || i_rf_wr)
      && (i_commit_src != vfp_pkg::COMMIT_FP || i_fp_rf_wr)
      && (i_commit_src != vfp_pkg::COMMIT_VECTOR || vec_ready)
      && (i_commit_src != vfp_pkg::COMMIT_STORE || store_acc))
      else begin
         $error("Commit source does not match the raised strobes");
         fail_cnt++;
      end

endmodule

bind vfp_commit_top vfp_commit_props u_props (
   .i_clk           (i_clk),
   .i_reset         (i_reset),
   .i_mu_req        (i_mu_req),
   .i_mu_load       (i_mu_load),
   .i_mu_store      (i_mu_store),
   .i_mu_byten      (i_mu_byten),
   .i_mu_req_id     (i_mu_req_id),
   .i_data_req_rtr  (i_data_req_rtr),
   .i_data_req      (o_data_req),
   .i_mem_last      (o_mem_last),
   .i_local_rsp_vld (o_local_rsp_vld),
   .i_local_rsp_id  (o_local_rsp_id),
   .i_rf_wr         (i_mem_rf_wr),
   .i_fp_rf_wr      (i_mem_fp_rf_wr),
   .i_vec_commit    (i_vec_nonstore_commit),
   .i_head_last     (u_lq_if.head_last),
   .i_commit_valid  (o_instrn_commit_valid),
   .i_commit_src    (u_assembler.commit_src)
);

// File: verification/vfp_commit_tb.sv
// Trace-driven testbench for the vector/FP commit and memory glue
`include "vfp_defs.svh"

module vfp_commit_tb;

   localparam int TRACE_W     = 148;
   localparam int TRACE_DEPTH = 64;
   localparam int DRAIN_LIMIT = 20;

   logic i_clk, i_reset, i_id_mem_lqalloc, i_id_mem_lq_done, i_mem_lq_commit;
   logic [`VFP_LQ_ID_W-1:0] i_mem_id_lqnxtid;
   logic [`VFP_VL_W-1:0] i_csr_vl;
   logic i_mu_req, i_mu_load, i_mu_store, i_mu_last, i_data_req_rtr;
   logic [`VFP_VLEN/8-1:0] i_mu_byten, o_data_byten;
   logic [`VFP_REQ_ID_W-1:0] i_mu_req_id, o_data_req_id, o_local_rsp_id;
   logic [`VFP_ADDR_W-1:0] i_mu_addr, o_data_addr;
   logic [`VFP_VLEN-1:0] i_mu_wrdata, o_wr_data, i_mem_vrf_wrdata;
   vfp_pkg::mem_size_e i_mu_size, o_mem_size;
   logic o_data_req, o_mem_load, o_mem_last, o_local_rsp_vld;
   logic i_mem_rf_wr, i_mem_fp_rf_wr, i_mem_vrf_wr, i_vec_nonstore_commit;
   logic [63:0] i_mem_rf_wrdata, i_mem_fp_rf_wrdata;
   logic [`VFP_EXC_W-1:0] i_mem_vrf_wrexc, o_instrn_commit_fflags;
   logic o_instrn_commit_valid;
   logic [`VFP_COMMIT_WIDTH-1:0] o_instrn_commit_data;
   logic [`VFP_GROUP_REGS-1:0] o_instrn_commit_mask;

   // One trace line, fields in file order
   logic [TRACE_W-1:0] trace_mem [0:TRACE_DEPTH-1];
   logic [3:0] t_test, t_ctla, t_lqid, t_ctlb, t_ctlc, t_eflags, t_ekind;
   logic [7:0] t_byten, t_reqid, t_vl, t_exc, t_emask, t_efflags, t_erspid;
   logic [63:0] t_data;

   logic [`VFP_VLEN-1:0] vec_slots[$];
   logic [3:0] cur_test = 4'h0;
   int err_count = 0;
   int test_errs = 0;
   int tests_run = 0;
   int tests_failed = 0;

   tb_clock_gen #(.PERIOD(100)) u_clk_gen (.o_clk(i_clk));

   vfp_commit_top u_dut (.*);

   task automatic check_value(input string name, input logic [`VFP_COMMIT_WIDTH-1:0] actual,
                              input logic [`VFP_COMMIT_WIDTH-1:0] expected);
      if (actual !== expected) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         err_count++;
         test_errs++;
      end
   endtask

   task automatic idle_inputs();
      {i_id_mem_lqalloc, i_id_mem_lq_done, i_mem_lq_commit, i_mu_req} <= 4'h0;
      {i_mu_load, i_mu_store, i_mu_last, i_data_req_rtr} <= 4'h0;
      {i_mem_rf_wr, i_mem_fp_rf_wr, i_mem_vrf_wr, i_vec_nonstore_commit} <= 4'h0;
      i_mem_id_lqnxtid <= '0;
      i_mu_byten <= '0;
      i_mu_req_id <= '0;
      i_csr_vl <= '0;
      i_mem_vrf_wrexc <= '0;
      i_mem_rf_wrdata <= '0;
      i_mem_fp_rf_wrdata <= '0;
      i_mem_vrf_wrdata <= '0;
      i_mu_addr <= '0;
      i_mu_wrdata <= '0;
      i_mu_size <= vfp_pkg::MEM_SIZE_BYTE;
   endtask

   task automatic drive_line();
      {i_id_mem_lqalloc, i_id_mem_lq_done, i_mem_lq_commit, i_mu_req} <= t_ctla;
      {i_mu_load, i_mu_store, i_mu_last, i_data_req_rtr} <= t_ctlb;
      {i_mem_rf_wr, i_mem_fp_rf_wr, i_mem_vrf_wr, i_vec_nonstore_commit} <= t_ctlc;
      i_mem_id_lqnxtid <= t_lqid[`VFP_LQ_ID_W-1:0];
      i_mu_byten <= t_byten;
      i_mu_req_id <= t_reqid;
      i_csr_vl <= t_vl[`VFP_VL_W-1:0];
      i_mem_vrf_wrexc <= t_exc[`VFP_EXC_W-1:0];
      // Write ports without their strobe carry random data
      i_mem_rf_wrdata <= t_ctlc[3] ? t_data : {$urandom, $urandom};
      i_mem_fp_rf_wrdata <= t_ctlc[2] ? t_data : {$urandom, $urandom};
      i_mem_vrf_wrdata <= t_ctlc[1] ? t_data : {$urandom, $urandom};
      // Pass-through fields carry no rule, any value will do
      i_mu_addr <= $urandom;
      i_mu_wrdata <= {$urandom, $urandom};
      i_mu_size <= vfp_pkg::mem_size_e'($urandom_range(4, 0));
   endtask

   // Expected payload from the line's kind: 1 low slot, 2 vector group, 3 empty
   function automatic logic [`VFP_COMMIT_WIDTH-1:0] expected_data();
      logic [`VFP_COMMIT_WIDTH-1:0] word;
      word = '0;
      if (t_ekind == 4'h1) begin
         word[63:0] = t_data;
      end else if (t_ekind == 4'h2) begin
         foreach (vec_slots[i]) word[`VFP_VLEN*i +: `VFP_VLEN] = vec_slots[i];
      end
      return word;
   endfunction

   task automatic check_line();
      check_value("o_data_req", o_data_req, t_eflags[3]);
      check_value("o_mem_last", o_mem_last, t_eflags[2]);
      check_value("o_instrn_commit_valid", o_instrn_commit_valid, t_eflags[1]);
      check_value("o_local_rsp_vld", o_local_rsp_vld, t_eflags[0]);
      if (t_eflags[0]) begin
         check_value("o_local_rsp_id", o_local_rsp_id, t_erspid);
      end
      check_value("o_instrn_commit_mask", o_instrn_commit_mask, t_emask);
      check_value("o_instrn_commit_fflags", o_instrn_commit_fflags, t_efflags);
      if (t_ekind != 4'h0) begin
         check_value("o_instrn_commit_data", o_instrn_commit_data, expected_data());
      end
      check_value("o_data_addr", o_data_addr, i_mu_addr);
      check_value("o_wr_data", o_wr_data, i_mu_wrdata);
      check_value("o_mem_size", o_mem_size, i_mu_size);
      check_value("o_data_req_id", o_data_req_id, t_reqid);
      check_value("o_data_byten", o_data_byten, t_byten);
      check_value("o_mem_load", o_mem_load, t_ctlb[3]);
   endtask

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'h1: return "scalar and FP commit";
         4'h2: return "vector group commit";
         4'h3: return "empty load local response";
         4'h4: return "store last gating";
         4'h5: return "idle after reset";
         default: return "unknown";
      endcase
   endfunction

   task automatic report_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("Test %0d %s: pass", cur_test, test_name(cur_test));
      end else begin
         tests_failed++;
         $display("Test %0d %s: fail, %0d mismatches", cur_test, test_name(cur_test), test_errs);
      end
   endtask

   initial begin
      int line;
      int wait_cnt;
      void'($urandom(32'h1e24));
      idle_inputs();
      i_reset <= 1'b1;
      $readmemh("verification/vfp_commit_trace.txt", trace_mem);
      repeat (16) @(posedge i_clk);
      i_reset <= 1'b0;
      if ($isunknown(trace_mem[0]) || trace_mem[0][TRACE_W-1 -: 4] == 4'h0) begin
         $display("Trace file could not be read or holds no cycles");
         err_count++;
      end
      line = 0;
      while (line < TRACE_DEPTH && !$isunknown(trace_mem[line])
             && trace_mem[line][TRACE_W-1 -: 4] != 4'h0) begin
         {t_test, t_ctla, t_lqid, t_ctlb, t_byten, t_reqid, t_ctlc, t_vl, t_exc, t_data,
          t_eflags, t_emask, t_efflags, t_erspid, t_ekind} = trace_mem[line];
         if (t_test != cur_test) begin
            if (cur_test != 4'h0) begin
               report_test();
            end
            cur_test = t_test;
            test_errs = 0;
         end
         @(posedge i_clk);
         drive_line();
         if (t_ctlc[1]) begin
            vec_slots.push_back(t_data);
         end
         @(negedge i_clk);
         check_line();
         // Any commit clears the group
         if (t_eflags[1]) begin
            vec_slots.delete();
         end
         line++;
      end
      if (cur_test != 4'h0) begin
         report_test();
      end
      @(posedge i_clk);
      idle_inputs();
      @(negedge i_clk);
      wait_cnt = 0;
      while ((o_instrn_commit_valid || o_local_rsp_vld) && wait_cnt < DRAIN_LIMIT) begin
         @(negedge i_clk);
         wait_cnt++;
      end
      if (o_instrn_commit_valid || o_local_rsp_vld) begin
         $display("Timeout: DUT outputs did not return to idle after the trace");
         err_count++;
      end
      if (u_dut.u_props.fail_cnt != 0) begin
         $display("Bound assertions failed %0d times", u_dut.u_props.fail_cnt);
         err_count += u_dut.u_props.fail_cnt;
      end
      $display("Tests run %0d, tests failed %0d, mismatches %0d",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: verification/vfp_commit_trace.txt
// test ctl{alloc,done,lqcommit,req} lqid ctl{load,store,last,rtr} byten reqid ctl{rf,fp,vrf,veccommit}
// vl exc data | exp{data_req,mem_last,commit_valid,rsp_vld} mask fflags rspid kind(1 low,2 group,3 zero)
5_0_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
5_0_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
1_0_0_0_00_00_8_00_00_0123456789abcdef_2_00_00_00_1
1_0_0_0_00_00_4_00_00_fedcba9876543210_2_00_00_00_1
2_8_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
2_0_0_0_00_00_2_04_01_a0a0a0a0a0a0a0a0_0_00_00_00_0
2_0_0_0_00_00_2_04_04_b1b1b1b1b1b1b1b1_0_00_00_00_0
2_0_0_0_00_00_2_04_00_c2c2c2c2c2c2c2c2_0_00_00_00_0
2_0_0_0_00_00_1_04_00_0000000000000000_0_00_00_00_0
2_4_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
2_0_0_0_00_00_3_04_10_d3d3d3d3d3d3d3d3_2_0f_15_00_2
2_2_0_0_00_00_2_00_02_e4e4e4e4e4e4e4e4_0_00_00_00_0
2_c_1_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
2_0_0_0_00_00_1_00_00_0000000000000000_2_00_02_00_2
3_1_0_9_00_5a_0_00_00_0000000000000000_0_00_00_00_0
3_0_0_0_00_00_0_00_00_0000000000000000_1_00_00_5a_0
3_1_0_8_00_3c_0_00_00_0000000000000000_0_00_00_00_0
3_1_0_9_00_3c_0_00_00_0000000000000000_0_00_00_00_0
3_0_0_0_00_00_0_00_00_0000000000000000_1_00_00_3c_0
3_1_0_9_ff_07_0_00_00_0000000000000000_8_00_00_00_0
3_0_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
4_8_2_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
4_1_0_7_ff_02_0_00_00_0000000000000000_8_00_00_00_0
4_4_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
4_1_0_6_ff_02_0_00_00_0000000000000000_c_00_00_00_0
4_1_0_6_ff_02_0_00_00_0000000000000000_c_00_00_00_0
4_1_0_7_ff_02_0_00_00_0000000000000000_e_00_00_00_3
4_c_3_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
4_1_0_7_ff_13_0_00_00_0000000000000000_e_00_00_00_3
4_0_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0
0_0_0_0_00_00_0_00_00_0000000000000000_0_00_00_00_0

// File: vfp_commit_top.f
+incdir+include
hdl/vfp_pkg.sv
hdl/lq_last_if.sv
hdl/lq_last_tracker.sv
hdl/mem_req_filter.sv
hdl/vec_commit_assembler.sv
hdl/vfp_commit_top.sv
verification/tb_clock_gen.sv
verification/vfp_commit_props.sv
verification/vfp_commit_tb.sv

// File: Bender.yml
package:
  name: vfp_commit

sources:
  - include_dirs:
      - include
    files:
      - hdl/vfp_pkg.sv
      - hdl/lq_last_if.sv
      - hdl/lq_last_tracker.sv
      - hdl/mem_req_filter.sv
      - hdl/vec_commit_assembler.sv
      - hdl/vfp_commit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/vfp_commit_props.sv
      - verification/vfp_commit_tb.sv
